//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen = 32;

    // Major opcodes
    localparam logic [6:0] op_lui      = 7'b0110111;
    localparam logic [6:0] op_auipc    = 7'b0010111;
    localparam logic [6:0] op_jal      = 7'b1101111;
    localparam logic [6:0] op_jalr     = 7'b1100111;
    localparam logic [6:0] op_branch   = 7'b1100011;
    localparam logic [6:0] op_load     = 7'b0000011;
    localparam logic [6:0] op_store    = 7'b0100011;
    localparam logic [6:0] op_op_imm   = 7'b0010011;
    localparam logic [6:0] op_op       = 7'b0110011;
    localparam logic [6:0] op_misc_mem = 7'b0001111;
    localparam logic [6:0] op_system   = 7'b1110011;

    // Branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Integer ALU functions, shared by OP and OP-IMM
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_view_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_view_t;

    // Same word, register or immediate layout
    typedef union packed {
        rv_r_view_t r;
        rv_i_view_t i;
    } rv_instr_u;

endpackage

//--- common/ctl_pkg.sv
package ctl_pkg;

    localparam int alu_sel_w   = 4;
    localparam int imm_sel_w   = 4;
    localparam int wb_sel_w    = 2;
    localparam int alu_class_w = 2;

    // ALU operations seen by the datapath
    localparam logic [alu_sel_w-1:0] alu_and    = 4'd0;
    localparam logic [alu_sel_w-1:0] alu_or     = 4'd1;
    localparam logic [alu_sel_w-1:0] alu_xor    = 4'd2;
    localparam logic [alu_sel_w-1:0] alu_add    = 4'd3;
    localparam logic [alu_sel_w-1:0] alu_sub    = 4'd4;
    localparam logic [alu_sel_w-1:0] alu_pass_b = 4'd6;
    localparam logic [alu_sel_w-1:0] alu_sll    = 4'd7;
    localparam logic [alu_sel_w-1:0] alu_srl    = 4'd8;
    localparam logic [alu_sel_w-1:0] alu_sra    = 4'd10;
    localparam logic [alu_sel_w-1:0] alu_sltu   = 4'd11;
    localparam logic [alu_sel_w-1:0] alu_slt    = 4'd12;

    // Immediate formats
    localparam logic [imm_sel_w-1:0] imm_r = 4'd0;
    localparam logic [imm_sel_w-1:0] imm_i = 4'd1;
    localparam logic [imm_sel_w-1:0] imm_s = 4'd2;
    localparam logic [imm_sel_w-1:0] imm_b = 4'd3;
    localparam logic [imm_sel_w-1:0] imm_u = 4'd4;
    localparam logic [imm_sel_w-1:0] imm_j = 4'd5;

    localparam logic [wb_sel_w-1:0] wb_mem = 2'd0;
    localparam logic [wb_sel_w-1:0] wb_alu = 2'd1;
    localparam logic [wb_sel_w-1:0] wb_pc4 = 2'd2;

    // ALU class between opcode and ALU decoders
    localparam logic [alu_class_w-1:0] cls_add    = 2'd0;
    localparam logic [alu_class_w-1:0] cls_pass_b = 2'd1;
    localparam logic [alu_class_w-1:0] cls_imm    = 2'd2;
    localparam logic [alu_class_w-1:0] cls_reg    = 2'd3;

endpackage

//--- rtl/opcode_decoder.sv
`timescale 1ns/1ps

module opcode_decoder (
    input  logic [6:0]                        opcode,
    output logic                              a_sel,
    output logic                              b_sel,
    output logic [ctl_pkg::imm_sel_w-1:0]     imm_sel,
    output logic                              mem_wr,
    output logic                              reg_wen,
    output logic [ctl_pkg::wb_sel_w-1:0]      wb_sel,
    output logic [ctl_pkg::alu_class_w-1:0]   alu_class,
    output logic                              is_jump,
    output logic                              is_branch
);

    import rv_isa_pkg::*;
    import ctl_pkg::*;

    always_comb begin
        // Everything off unless the opcode says otherwise
        a_sel     = 1'b0;
        b_sel     = 1'b0;
        imm_sel   = imm_r;
        mem_wr    = 1'b0;
        reg_wen   = 1'b0;
        wb_sel    = wb_mem;
        alu_class = cls_add;
        is_jump   = 1'b0;
        is_branch = 1'b0;

        case (opcode)
            op_lui: begin
                b_sel     = 1'b1;
                imm_sel   = imm_u;
                reg_wen   = 1'b1;
                wb_sel    = wb_alu;
                alu_class = cls_pass_b;
            end
            op_auipc: begin
                a_sel   = 1'b1;
                b_sel   = 1'b1;
                imm_sel = imm_u;
                reg_wen = 1'b1;
                wb_sel  = wb_alu;
            end
            op_jal: begin
                a_sel   = 1'b1;
                b_sel   = 1'b1;
                imm_sel = imm_j;
                reg_wen = 1'b1;
                wb_sel  = wb_pc4;
                is_jump = 1'b1;
            end
            // Target is rs1 plus offset, link is pc+4
            op_jalr: begin
                b_sel   = 1'b1;
                imm_sel = imm_i;
                reg_wen = 1'b1;
                wb_sel  = wb_pc4;
                is_jump = 1'b1;
            end
            // ALU forms pc plus offset as the branch target
            op_branch: begin
                a_sel     = 1'b1;
                b_sel     = 1'b1;
                imm_sel   = imm_b;
                is_branch = 1'b1;
            end
            op_load: begin
                b_sel   = 1'b1;
                imm_sel = imm_i;
                reg_wen = 1'b1;
                wb_sel  = wb_mem;
            end
            op_store: begin
                b_sel   = 1'b1;
                imm_sel = imm_s;
                mem_wr  = 1'b1;
            end
            op_op_imm: begin
                b_sel     = 1'b1;
                imm_sel   = imm_i;
                reg_wen   = 1'b1;
                wb_sel    = wb_alu;
                alu_class = cls_imm;
            end
            op_op: begin
                imm_sel   = imm_r;
                reg_wen   = 1'b1;
                wb_sel    = wb_alu;
                alu_class = cls_reg;
            end
            // No architectural effect here
            op_misc_mem, op_system: begin
                reg_wen = 1'b0;
            end
            default: begin
                reg_wen = 1'b0;
            end
        endcase
    end

endmodule

//--- rtl/alu_op_decoder.sv
`timescale 1ns/1ps

module alu_op_decoder (
    input  logic [ctl_pkg::alu_class_w-1:0] alu_class,
    input  logic [2:0]                      funct3,
    input  logic                            alt,
    output logic [ctl_pkg::alu_sel_w-1:0]   alu_sel
);

    import rv_isa_pkg::*;
    import ctl_pkg::*;

    logic [alu_sel_w-1:0] func_op;

    // Function-field decode shared by OP and OP-IMM
    always_comb begin
        func_op = alu_and;
        case (funct3)
            f3_add: begin
                // ADDI has no subtract form, bit 30 is immediate there
                if (alt && alu_class == cls_reg) begin
                    func_op = alu_sub;
                end else begin
                    func_op = alu_add;
                end
            end
            f3_sll:  func_op = alu_sll;
            f3_slt:  func_op = alu_slt;
            f3_sltu: func_op = alu_sltu;
            f3_xor:  func_op = alu_xor;
            f3_sr: begin
                if (alt) begin
                    func_op = alu_sra;
                end else begin
                    func_op = alu_srl;
                end
            end
            f3_or:   func_op = alu_or;
            f3_and:  func_op = alu_and;
            default: func_op = alu_and;
        endcase
    end

    always_comb begin
        case (alu_class)
            cls_add:    alu_sel = alu_add;
            cls_pass_b: alu_sel = alu_pass_b;
            cls_imm:    alu_sel = func_op;
            cls_reg:    alu_sel = func_op;
            default:    alu_sel = alu_and;
        endcase
    end

endmodule

//--- rtl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic       is_jump,
    input  logic       is_branch,
    input  logic       br_eq,
    input  logic       br_lt,
    input  logic [2:0] funct3,
    output logic       br_un,
    output logic       pc_sel
);

    import rv_isa_pkg::*;

    // Unsigned compare for BLTU and BGEU
    assign br_un = is_branch & funct3[1];

    always_comb begin
        pc_sel = 1'b0;
        if (is_jump) begin
            pc_sel = 1'b1;
        end else if (is_branch) begin
            case (funct3)
                f3_beq:  pc_sel = br_eq;
                f3_bne:  pc_sel = ~br_eq;
                f3_blt:  pc_sel = br_lt;
                f3_bge:  pc_sel = ~br_lt;
                f3_bltu: pc_sel = br_lt;
                f3_bgeu: pc_sel = ~br_lt;
                // Reserved encodings never redirect
                default: pc_sel = 1'b0;
            endcase
        end
    end

endmodule

//--- rtl/instr_ctl.sv
`timescale 1ns/1ps

module instr_ctl (
    input  rv_isa_pkg::rv_instr_u           instruction,
    input  logic                            br_eq,
    input  logic                            br_lt,
    output logic                            a_sel,
    output logic                            b_sel,
    output logic [ctl_pkg::alu_sel_w-1:0]   alu_sel,
    output logic                            mem_wr,
    output logic                            reg_wen,
    output logic [ctl_pkg::imm_sel_w-1:0]   imm_sel,
    output logic                            br_un,
    output logic                            pc_sel,
    output logic [ctl_pkg::wb_sel_w-1:0]    wb_sel
);

    import ctl_pkg::*;

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic                   alt;
    logic [alu_class_w-1:0] alu_class;
    logic                   is_jump;
    logic                   is_branch;

    assign opcode = instruction.i.opcode;
    assign funct3 = instruction.r.funct3;
    // Bit 30 picks SUB and SRA
    assign alt    = instruction.r.funct7[5];

    opcode_decoder opcode_decoder_i (
        .opcode    (opcode),
        .a_sel     (a_sel),
        .b_sel     (b_sel),
        .imm_sel   (imm_sel),
        .mem_wr    (mem_wr),
        .reg_wen   (reg_wen),
        .wb_sel    (wb_sel),
        .alu_class (alu_class),
        .is_jump   (is_jump),
        .is_branch (is_branch)
    );

    alu_op_decoder alu_op_decoder_i (
        .alu_class (alu_class),
        .funct3    (funct3),
        .alt       (alt),
        .alu_sel   (alu_sel)
    );

    branch_unit branch_unit_i (
        .is_jump   (is_jump),
        .is_branch (is_branch),
        .br_eq     (br_eq),
        .br_lt     (br_lt),
        .funct3    (funct3),
        .br_un     (br_un),
        .pc_sel    (pc_sel)
    );

endmodule

//--- verification/tb_instr_ctl.sv
`timescale 1ns/1ps

module tb_instr_ctl;

    import rv_isa_pkg::*;
    import ctl_pkg::*;

    // One vector per cycle, with margin for reset and drain
    localparam int num_vectors = 64 + 32 + 32 + 32 + 5 + 2000;
    localparam int cycle_limit = num_vectors + 100;

    logic                 clk;
    logic                 rst_n;
    rv_instr_u            instruction;
    logic                 br_eq;
    logic                 br_lt;
    logic                 a_sel;
    logic                 b_sel;
    logic [alu_sel_w-1:0] alu_sel;
    logic                 mem_wr;
    logic                 reg_wen;
    logic [imm_sel_w-1:0] imm_sel;
    logic                 br_un;
    logic                 pc_sel;
    logic [wb_sel_w-1:0]  wb_sel;
    logic                 vec_valid;
    string                cur_test;
    int                   cycles;

    instr_ctl instr_ctl_i (
        .instruction (instruction),
        .br_eq       (br_eq),
        .br_lt       (br_lt),
        .a_sel       (a_sel),
        .b_sel       (b_sel),
        .alu_sel     (alu_sel),
        .mem_wr      (mem_wr),
        .reg_wen     (reg_wen),
        .imm_sel     (imm_sel),
        .br_un       (br_un),
        .pc_sel      (pc_sel),
        .wb_sel      (wb_sel)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [alu_sel_w-1:0] ref_alu(input logic [2:0] f3, input logic alt,
                                                     input logic reg_op);
        case (f3)
            3'b000:  return (alt && reg_op) ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // Expected outputs in port order, {a_sel, b_sel, alu_sel, mem_wr, reg_wen, ...}
    function automatic logic [15:0] ref_ctl(input logic [31:0] word, input logic eq,
                                            input logic lt);
        logic [6:0]           opc;
        logic [2:0]           f3;
        logic [1:0]           ab;
        logic [1:0]           wm;
        logic [1:0]           jb;
        logic [imm_sel_w-1:0] imm;
        logic [wb_sel_w-1:0]  wb;
        logic [alu_sel_w-1:0] alu;
        logic                 cond;
        logic                 un;
        logic                 pc;
        opc = word[6:0];
        f3  = word[14:12];
        // Row: {a_sel, b_sel}, imm, {mem_wr, reg_wen}, wb, {jump, branch}
        case (opc)
            op_lui:    {ab, imm, wm, wb, jb} = {2'b01, imm_u, 2'b01, wb_alu, 2'b00};
            op_auipc:  {ab, imm, wm, wb, jb} = {2'b11, imm_u, 2'b01, wb_alu, 2'b00};
            op_jal:    {ab, imm, wm, wb, jb} = {2'b11, imm_j, 2'b01, wb_pc4, 2'b10};
            op_jalr:   {ab, imm, wm, wb, jb} = {2'b01, imm_i, 2'b01, wb_pc4, 2'b10};
            op_branch: {ab, imm, wm, wb, jb} = {2'b11, imm_b, 2'b00, wb_mem, 2'b01};
            op_load:   {ab, imm, wm, wb, jb} = {2'b01, imm_i, 2'b01, wb_mem, 2'b00};
            op_store:  {ab, imm, wm, wb, jb} = {2'b01, imm_s, 2'b10, wb_mem, 2'b00};
            op_op_imm: {ab, imm, wm, wb, jb} = {2'b01, imm_i, 2'b01, wb_alu, 2'b00};
            op_op:     {ab, imm, wm, wb, jb} = {2'b00, imm_r, 2'b01, wb_alu, 2'b00};
            default:   {ab, imm, wm, wb, jb} = {2'b00, imm_r, 2'b00, wb_mem, 2'b00};
        endcase
        // ALU idles at add outside LUI and the integer ops
        if (opc == op_lui) begin
            alu = alu_pass_b;
        end else if (opc == op_op_imm) begin
            alu = ref_alu(f3, word[30], 1'b0);
        end else if (opc == op_op) begin
            alu = ref_alu(f3, word[30], 1'b1);
        end else begin
            alu = alu_add;
        end
        un = 1'b0;
        pc = jb[1];
        if (jb[0]) begin
            un = f3[1];
            // funct3[2] picks less-than, funct3[0] inverts the sense
            cond = f3[2] ? lt : eq;
            pc = (f3[2:1] != 2'b01) && (cond ^ f3[0]);
        end
        return {ab, alu, wm, imm, un, pc, wb};
    endfunction

    task automatic check_eq(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Decoder outputs differ from the reference model");
        end
    endtask

    function automatic logic [31:0] make_word(input logic [6:0] opc, input logic [2:0] f3,
                                              input logic alt);
        logic [31:0] w;
        w = $urandom();
        w[30] = alt;
        w[14:12] = f3;
        w[6:0] = opc;
        return w;
    endfunction

    function automatic logic [31:0] rand_word(input logic [6:0] opc);
        logic [31:0] w;
        w = $urandom();
        w[6:0] = opc;
        return w;
    endfunction

    function automatic logic [1:0] rand_flags();
        logic [31:0] r;
        r = $urandom();
        return r[1:0];
    endfunction

    // Flags are {br_eq, br_lt}
    task automatic apply(input string name, input logic [31:0] word, input logic [1:0] flags);
        @(negedge clk);
        cur_test = name;
        instruction = word;
        br_eq = flags[1];
        br_lt = flags[0];
        vec_valid = 1'b1;
    endtask

    always @(posedge clk) begin
        if (rst_n && vec_valid) begin
            check_eq(cur_test, ref_ctl(instruction, br_eq, br_lt),
                     {a_sel, b_sel, alu_sel, mem_wr, reg_wen, imm_sel, br_un, pc_sel, wb_sel});
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Run hung: still going after %0d cycles", cycles);
            $display("TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        void'($urandom(94));
        cycles = 0;
        rst_n = 1'b0;
        instruction = '0;
        br_eq = 1'b0;
        br_lt = 1'b0;
        vec_valid = 1'b0;
        cur_test = "reset";
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int n = 0; n < 16; n++) begin
            apply("lui", rand_word(op_lui), rand_flags());
            apply("auipc", rand_word(op_auipc), rand_flags());
            apply("jal", rand_word(op_jal), rand_flags());
            apply("jalr", rand_word(op_jalr), rand_flags());
        end
        // Includes the reserved codes 010 and 011
        for (int f = 0; f < 8; f++) begin
            for (int c = 0; c < 4; c++) begin
                apply("branch", make_word(op_branch, f[2:0], 1'b0), c[1:0]);
            end
        end
        for (int n = 0; n < 16; n++) begin
            apply("load", rand_word(op_load), rand_flags());
            apply("store", rand_word(op_store), rand_flags());
        end
        for (int f = 0; f < 8; f++) begin
            for (int a = 0; a < 2; a++) begin
                apply("op", make_word(op_op, f[2:0], a[0]), rand_flags());
                apply("op_imm", make_word(op_op_imm, f[2:0], a[0]), rand_flags());
            end
        end
        apply("fence", rand_word(op_misc_mem), rand_flags());
        apply("system", rand_word(op_system), rand_flags());
        apply("unknown", rand_word(7'h7f), rand_flags());
        apply("unknown", rand_word(7'h00), rand_flags());
        apply("unknown", rand_word(7'h5b), rand_flags());
        for (int n = 0; n < 2000; n++) begin
            apply("random", $urandom(), rand_flags());
        end

        @(negedge clk);
        vec_valid = 1'b0;
        @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- files.f
common/rv_isa_pkg.sv
common/ctl_pkg.sv
rtl/opcode_decoder.sv
rtl/alu_op_decoder.sv
rtl/branch_unit.sv
rtl/instr_ctl.sv
verification/tb_instr_ctl.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_instr_ctl
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

# Build the simulation executable
compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Exit status is nonzero when the testbench fails
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
